// File: hdl/banked_mem_pkg.sv
// Shared types for the banked memory: data word, word address and request.
// RTL modules import this package; ports use scoped names.

package banked_mem_pkg;

  // data word width in bits
  localparam int word_width = 32;

  // word address width at the request port, 1024 words
  localparam int addr_width = 10;

  // upper limit on the bank count
  // sizes the bank index carried from the decoder to the read mux
  localparam int max_banks = 16;

  typedef logic [word_width-1:0] word_t;

  typedef logic [addr_width-1:0] addr_t;

  // one request per cycle
  // v set with w set is a write
  // v set with w clear is a read
  // data only matters on a write
  typedef struct packed {
    logic  v;
    logic  w;
    addr_t addr;
    word_t data;
  } mem_req_t;

endpackage

// File: hdl/mem_bank_1rw_sync.sv
// One synchronous single-port RAM bank with a registered read address.
// The read word appears the cycle after the read request; writes land at the request edge.

module mem_bank_1rw_sync
  #(parameter int els_p = 256
    , localparam int addr_width_lp = $clog2(els_p)
  )
  (
    input                          clk_i
    , input                        v_i
    , input                        w_i
    , input [addr_width_lp-1:0]    addr_i
    , input banked_mem_pkg::word_t data_i
    , output banked_mem_pkg::word_t data_o
  );

  import banked_mem_pkg::*;

  // storage array, no reset
  word_t mem [els_p];

  // row of the last read
  logic [addr_width_lp-1:0] addr_r;

  logic read_en;
  logic write_en;

  assign read_en  = v_i & ~w_i;
  assign write_en = v_i & w_i;

  // capture the row only on a read
  // the registered row keeps its value through writes and idle cycles
  always_ff @(posedge clk_i)
  begin
    if (read_en)
    begin
      addr_r <= addr_i;
    end
  end

  // write at the request edge
  always_ff @(posedge clk_i)
  begin
    if (write_en)
    begin
      mem[addr_i] <= data_i;
    end
  end

  // combinational array read from the registered row
  // only guaranteed in the cycle right after a read
  // (a write to the same row in that cycle shows up here too, the mux
  // takes the word before that edge anyway)
  assign data_o = mem[addr_r];

endmodule

// File: hdl/bank_req_decode.sv
// Request decoder: low address bits pick the bank, high bits form the row.
// Also registers the bank of each read so the read mux knows which word to take.

module bank_req_decode
  #(parameter int num_banks_p = 4
    , localparam int bank_bits_lp = $clog2(num_banks_p)
    , localparam int row_width_lp = banked_mem_pkg::addr_width - bank_bits_lp
    , localparam int idx_width_lp = $clog2(banked_mem_pkg::max_banks)
  )
  (
    input                                clk_i
    , input                              rst_i
    , input banked_mem_pkg::mem_req_t    req_i
    , output logic [num_banks_p-1:0]     bank_v_o
    , output logic                       bank_w_o
    , output logic [row_width_lp-1:0]    row_o
    , output banked_mem_pkg::word_t      wdata_o
    , output logic [idx_width_lp-1:0]    rd_bank_o
    , output logic                       rd_fire_o
  );

  import banked_mem_pkg::*;

  // bank number from the low address bits
  logic [idx_width_lp-1:0] bank_idx;

  // read sampled this cycle
  logic rd_req;

  // num_banks_p is a power of two, so the mask keeps exactly the bank bits
  assign bank_idx = idx_width_lp'(req_i.addr & addr_t'(num_banks_p - 1));

  assign rd_req = req_i.v & ~req_i.w;

  // one-hot strobe gated by valid
  always_comb
  begin
    bank_v_o = '0;
    for (int k = 0; k < num_banks_p; k++)
    begin
      bank_v_o[k] = req_i.v && (bank_idx == idx_width_lp'(k));
    end
  end

  // shared by every bank
  assign bank_w_o = req_i.w;
  assign row_o    = req_i.addr[addr_width-1:bank_bits_lp];
  assign wdata_o  = req_i.data;

  // bank of the last read, only meaningful while rd_fire_o is high
  always_ff @(posedge clk_i)
  begin
    if (rd_req)
    begin
      rd_bank_o <= bank_idx;
    end
  end

  // one-cycle pulse, the cycle after a read is sampled
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rd_fire_o <= 1'b0;
    end
    else
    begin
      rd_fire_o <= rd_req;
    end
  end

endmodule

// File: hdl/bank_read_mux.sv
// Read-side mux: picks the word of the bank read one cycle earlier.
// Holds the last read result until the next read completes, and pulses read-valid.

module bank_read_mux
  #(parameter int num_banks_p = 4
    , localparam int idx_width_lp = $clog2(banked_mem_pkg::max_banks)
  )
  (
    input                                                 clk_i
    , input                                               rst_i
    , input banked_mem_pkg::word_t [num_banks_p-1:0]      bank_rdata_i
    , input [idx_width_lp-1:0]                            rd_bank_i
    , input                                               rd_fire_i
    , output banked_mem_pkg::word_t                       rdata_o
    , output logic                                        rd_valid_o
  );

  import banked_mem_pkg::*;

  // word of the bank named by rd_bank_i
  word_t sel_word;

  // last read result
  word_t hold_r;

  // compare against every bank number so all index bits take part
  always_comb
  begin
    sel_word = '0;
    for (int k = 0; k < num_banks_p; k++)
    begin
      if (rd_bank_i == idx_width_lp'(k))
      begin
        sel_word = bank_rdata_i[k];
      end
    end
  end

  // capture at the end of the fire cycle
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      hold_r <= '0;
    end
    else if (rd_fire_i)
    begin
      hold_r <= sel_word;
    end
  end

  // bypass during the fire cycle, held value otherwise
  assign rdata_o = rd_fire_i ? sel_word : hold_r;

  assign rd_valid_o = rd_fire_i;

endmodule

// File: hdl/banked_mem_top.sv
// Banked single-port memory: decoder, a generate loop of RAM banks, read mux.
// One read or write per cycle on req_i; read data follows one cycle later.

module banked_mem_top
  #(parameter int num_banks_p = 4
    , localparam int words_lp = 2 ** banked_mem_pkg::addr_width
    , localparam int els_lp = words_lp / num_banks_p
    , localparam int row_width_lp = $clog2(els_lp)
  )
  (
    input                              clk_i
    , input                            rst_i
    , input banked_mem_pkg::mem_req_t  req_i
    , output banked_mem_pkg::word_t    rdata_o
    , output logic                     rd_valid_o
  );

  import banked_mem_pkg::*;

  // request side, shared except for the strobes
  logic [num_banks_p-1:0]  bank_v;
  logic                    bank_w;
  logic [row_width_lp-1:0] row;
  word_t                   wdata;

  // read side
  word_t [num_banks_p-1:0]       bank_rdata;
  logic [$clog2(max_banks)-1:0]  rd_bank;
  logic                          rd_fire;

  bank_req_decode #(
    .num_banks_p(num_banks_p)
  ) u_decode (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.req_i(req_i)
    ,.bank_v_o(bank_v)
    ,.bank_w_o(bank_w)
    ,.row_o(row)
    ,.wdata_o(wdata)
    ,.rd_bank_o(rd_bank)
    ,.rd_fire_o(rd_fire)
  );

  // interleaved banks, bank k holds addresses with low bits equal to k
  for (genvar k = 0; k < num_banks_p; k++)
  begin : g_bank
    mem_bank_1rw_sync #(
      .els_p(els_lp)
    ) u_bank (
      .clk_i(clk_i)
      ,.v_i(bank_v[k])
      ,.w_i(bank_w)
      ,.addr_i(row)
      ,.data_i(wdata)
      ,.data_o(bank_rdata[k])
    );
  end

  bank_read_mux #(
    .num_banks_p(num_banks_p)
  ) u_read_mux (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.bank_rdata_i(bank_rdata)
    ,.rd_bank_i(rd_bank)
    ,.rd_fire_i(rd_fire)
    ,.rdata_o(rdata_o)
    ,.rd_valid_o(rd_valid_o)
  );

endmodule

// File: verification/banked_mem_sva.sv
// Protocol assertions for the banked memory, attached to banked_mem_top by bind.
// Covers read-valid timing, held read data and the one-hot bank strobe.

module banked_mem_sva
  #(parameter int num_banks_p = 4)
  (
    input                              clk_i
    , input                            rst_i
    , input banked_mem_pkg::mem_req_t  req_i
    , input banked_mem_pkg::word_t     rdata_i
    , input                            rd_valid_i
    , input [num_banks_p-1:0]          bank_v_i
  );

  timeunit 1ns;
  timeprecision 100ps;

  logic rd_req;

  assign rd_req = req_i.v & ~req_i.w;

  a_valid_low_after_reset: assert property (@(posedge clk_i) rst_i |=> !rd_valid_i)
    else $error("rd_valid_o high right after reset");

  a_valid_after_read: assert property (@(posedge clk_i) disable iff (rst_i)
    rd_req |=> rd_valid_i)
    else $error("rd_valid_o missing after a read");

  a_no_valid_without_read: assert property (@(posedge clk_i) disable iff (rst_i)
    !rd_req |=> !rd_valid_i)
    else $error("rd_valid_o high without a read");

  // held word only changes in a read-valid cycle
  a_rdata_held: assert property (@(posedge clk_i) disable iff (rst_i)
    !rd_valid_i |-> $stable(rdata_i))
    else $error("rdata_o changed outside a read-valid cycle");

  // exactly one strobe per valid request, none otherwise
  a_one_bank: assert property (@(posedge clk_i)
    req_i.v ? $onehot(bank_v_i) : (bank_v_i == '0))
    else $error("bank strobes do not match the request");

endmodule

bind banked_mem_top banked_mem_sva #(
  .num_banks_p(num_banks_p)
) u_sva (
  .clk_i(clk_i)
  ,.rst_i(rst_i)
  ,.req_i(req_i)
  ,.rdata_i(rdata_o)
  ,.rd_valid_i(rd_valid_o)
  ,.bank_v_i(bank_v)
);

// File: verification/banked_mem_tb.sv
// Testbench for the banked memory: LFSR-driven requests checked against a word-array model.
// Compile with build.f; banked_mem_tb is the top module.

module banked_mem_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import banked_mem_pkg::*;

  localparam int num_words = 2 ** addr_width;
  localparam int reset_timeout = 20;

  logic     clk_i;
  logic     rst_i;
  mem_req_t req;
  word_t    rdata;
  logic     rd_valid;

  // reference model of the whole memory and of the read port
  word_t    model_mem [num_words];
  word_t    exp_word;
  logic     exp_valid;
  // request driven last, sampled by the DUT at the next edge
  mem_req_t pending;

  logic [15:0] lfsr_state;

  banked_mem_top #(
    .num_banks_p(4)
  ) u_dut (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.req_i(req)
    ,.rdata_o(rdata)
    ,.rd_valid_o(rd_valid)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial
  begin
    rst_i = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic mem_req_t make_req(input logic v, input logic w, input addr_t addr,
                                        input word_t data);
    mem_req_t r;
    r.v = v;
    r.w = w;
    r.addr = addr;
    r.data = data;
    return r;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      $display("Test failures found");
      $fatal(1, "word compare failed");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      $display("Test failures found");
      $fatal(1, "bit compare failed");
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_i !== 1'b0)
    begin
      @(posedge clk_i);
      cycles++;
      if (cycles > reset_timeout)
      begin
        $display("reset was never released");
        $display("Test failures found");
        $fatal(1, "reset wait timed out");
      end
    end
  endtask

  // one clock cycle: model the request sampled at this edge, drive the next one,
  // then check the read port in the middle of the cycle
  task automatic step(input mem_req_t next_req);
    @(posedge clk_i);
    exp_valid = pending.v & ~pending.w;
    if (exp_valid)
    begin
      exp_word = model_mem[pending.addr];
    end
    if (pending.v && pending.w)
    begin
      model_mem[pending.addr] = pending.data;
    end
    req <= next_req;
    pending = next_req;
    @(negedge clk_i);
    check_bit("rd_valid_o", rd_valid, exp_valid);
    check_word("rdata_o", rdata, exp_word);
  endtask

  initial
  begin
    addr_t a;
    addr_t prev_a;
    logic  v;
    logic  w;
    word_t d;
    req = '0;
    pending = '0;
    exp_word = '0;
    exp_valid = 1'b0;
    lfsr_state = 16'd28572;
    prev_a = '0;
    wait_reset_release();

    // idle after reset
    for (int i = 0; i < 6; i++)
    begin
      step(make_req(1'b0, 1'b0, '0, '0));
    end

    // fill every word, then read them back in order across all banks
    for (int i = 0; i < num_words; i++)
    begin
      d = rand_bits(word_width);
      step(make_req(1'b1, 1'b1, addr_t'(i), d));
    end
    for (int i = 0; i < num_words; i++)
    begin
      step(make_req(1'b1, 1'b0, addr_t'(i), '0));
    end

    // back-to-back reads, every odd one hits the bank of the read before it
    for (int i = 0; i < 400; i++)
    begin
      a = addr_t'(rand_bits(addr_width));
      if (i % 2 == 1)
      begin
        a[1:0] = prev_a[1:0];
      end
      step(make_req(1'b1, 1'b0, a, '0));
      prev_a = a;
    end

    // held result survives idle cycles and writes, also to the same word
    for (int i = 0; i < 20; i++)
    begin
      a = addr_t'(rand_bits(addr_width));
      step(make_req(1'b1, 1'b0, a, '0));
      step(make_req(1'b0, 1'b0, '0, '0));
      step(make_req(1'b1, 1'b1, a, rand_bits(word_width)));
      step(make_req(1'b1, 1'b1, addr_t'(rand_bits(addr_width)), rand_bits(word_width)));
      step(make_req(1'b0, 1'b0, '0, '0));
    end

    // long random mix
    for (int i = 0; i < 3000; i++)
    begin
      v = (rand_bits(2) != 32'd0);
      w = (rand_bits(1) == 32'd1);
      a = addr_t'(rand_bits(addr_width));
      d = rand_bits(word_width);
      step(make_req(v, w, a, d));
    end

    // drain the last result
    step(make_req(1'b0, 1'b0, '0, '0));
    step(make_req(1'b0, 1'b0, '0, '0));

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: build.f
hdl/banked_mem_pkg.sv
hdl/mem_bank_1rw_sync.sv
hdl/bank_req_decode.sv
hdl/bank_read_mux.sv
hdl/banked_mem_top.sv
verification/banked_mem_sva.sv
verification/banked_mem_tb.sv

// File: Makefile
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 -f build.f --top-module banked_mem_tb -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/Vbanked_mem_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "All tests passed!" $(LOG); then echo "FAIL: run did not complete"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
